// File: logic/pkt_pkg.sv
// packet word and control types, header and barrier field positions, buffer depths
package pkt_pkg;

   // -------------------------------------------------------------------------
   // word format
   // -------------------------------------------------------------------------
   localparam int DATA_W = 64;
   localparam int CTRL_W = DATA_W / 8;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [CTRL_W-1:0] ctrl_t;
   typedef logic [15:0]       port_mask_t;  // one-hot output ports
   typedef logic [15:0]       port_num_t;
   typedef logic [2:0]        word_idx_t;   // saturates at 7

   // module header, word 0
   localparam ctrl_t IOQ_HDR_CTRL = 8'hff;
   localparam int    DST_MASK_LSB = 0;
   localparam int    SRC_PORT_LSB = 16;

   // barrier payload
   localparam int          ETHERTYPE_WORD    = 2;
   localparam int          ETHERTYPE_LSB     = 48;
   localparam logic [15:0] BARRIER_ETHERTYPE = 16'h88b5;
   localparam int          BARRIER_WORD      = 3;
   localparam int          MSG_LSB           = 32;   // comm id sits below, 31..16
   localparam int          TOPO_LSB          = 8;
   localparam int          NODE_LSB          = 0;

   // -------------------------------------------------------------------------
   // buffering
   // -------------------------------------------------------------------------
   localparam int DATA_FIFO_DEPTH_BITS = 4;
   localparam int DESC_FIFO_DEPTH_BITS = 2;
   localparam int DESC_W               = 49;  // flag + src port + msg + topo + node

endpackage

// File: logic/barrier_pkg.sv
// barrier message codes, topology and node type codes, ring barrier state enum
package barrier_pkg;

   typedef logic [15:0] msg_t;
   typedef logic [7:0]  topo_t;
   typedef logic [7:0]  node_t;

   // messages passed around the ring
   localparam msg_t MSG_AT_BR      = 16'd65;  // local cpu reached the barrier
   localparam msg_t MSG_PREV_AT_BR = 16'd66;  // all upstream nodes are waiting
   localparam msg_t MSG_RLS_BR     = 16'd67;  // release, sent by the head

   // only the ring is decoded here
   localparam topo_t TOPO_RING = 8'd1;

   localparam node_t NODE_HEAD = 8'd1;
   localparam node_t NODE_NODE = 8'd2;       // regular ring member

   // at_barrier is used by the head only, the wait states by regular nodes
   typedef enum logic [2:0] {
      br_idle,
      at_barrier,
      wait_cpu,
      wait_network,
      wait_notification
   } br_state_e;

endpackage

// File: logic/pkt_fifo.sv
// synchronous register-array FIFO with registered read data and nearly-full flag
module pkt_fifo #(
   parameter int WIDTH      = 72,
   parameter int DEPTH_BITS = 4
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] din,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             nearly_full,
   output logic             full
);

   logic [WIDTH-1:0]      mem [2**DEPTH_BITS];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;     // one extra bit to tell full from empty

   // storage, read data shows up the cycle after rd_en
   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= din;
      if (rd_en)
         dout <= mem[rd_ptr];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign empty       = (count == '0);
   assign full        = count[DEPTH_BITS];                        // only set at 2**DEPTH_BITS
   assign nearly_full = full || (count[DEPTH_BITS-1:0] == '1);    // one entry left

   a_no_overflow: assert property (@(posedge clk) disable iff (reset) full |-> !wr_en)
      else $error("write into a full fifo");
   a_no_underflow: assert property (@(posedge clk) disable iff (reset) empty |-> !rd_en)
      else $error("read from an empty fifo");

endmodule

// File: logic/barrier_parser.sv
// input word counter, source port capture and barrier field extraction into a descriptor
module barrier_parser (
   input  logic               clk,
   input  logic               reset,
   input  pkt_pkg::data_t     in_data,
   input  pkt_pkg::ctrl_t     in_ctrl,
   input  logic               in_wr,
   output logic               desc_wr,
   output logic               is_barrier,
   output pkt_pkg::port_num_t src_port,
   output barrier_pkg::msg_t  message,
   output barrier_pkg::topo_t topo,
   output barrier_pkg::node_t node
);
   import pkt_pkg::*;
   import barrier_pkg::*;

   word_idx_t word_cnt;
   logic      eth_match;      // word 2 carried the barrier ethertype
   port_num_t src_q;
   msg_t      msg_q;
   topo_t     topo_q;
   node_t     node_q;
   logic      at_fields;

   assign at_fields = (word_cnt == word_idx_t'(BARRIER_WORD));

   // last word is any nonzero control other than the module header code
   assign desc_wr = in_wr && (in_ctrl != '0) && (in_ctrl != IOQ_HDR_CTRL);

   // -------------------------------------------------------------------------
   // word tracking
   // -------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         word_cnt  <= '0;
         eth_match <= 1'b0;
      end else if (in_wr) begin
         if (desc_wr)
            word_cnt <= '0;
         else if (word_cnt != '1)
            word_cnt <= word_cnt + 1'b1;
         if (word_cnt == word_idx_t'(ETHERTYPE_WORD))
            eth_match <= (in_data[ETHERTYPE_LSB +: 16] == BARRIER_ETHERTYPE);
      end
   end

   // field capture
   always_ff @(posedge clk) begin
      if (in_wr && word_cnt == '0)
         src_q <= in_data[SRC_PORT_LSB +: $bits(port_num_t)];
      if (in_wr && at_fields) begin
         msg_q  <= in_data[MSG_LSB +: $bits(msg_t)];
         topo_q <= in_data[TOPO_LSB +: $bits(topo_t)];
         node_q <= in_data[NODE_LSB +: $bits(node_t)];
      end
   end

   // -------------------------------------------------------------------------
   // descriptor, word 3 taken straight from the bus when it is the last word
   // -------------------------------------------------------------------------
   assign is_barrier = eth_match && (word_cnt >= word_idx_t'(BARRIER_WORD));
   assign src_port   = src_q;
   assign message    = at_fields ? in_data[MSG_LSB +: $bits(msg_t)] : msg_q;
   assign topo       = at_fields ? in_data[TOPO_LSB +: $bits(topo_t)] : topo_q;
   assign node       = at_fields ? in_data[NODE_LSB +: $bits(node_t)] : node_q;

endmodule

// File: logic/forward_decision.sv
// ring barrier state machine and neighbour port mapping for plain traffic
module forward_decision (
   input  logic                clk,
   input  logic                reset,
   input  logic                is_barrier,
   input  pkt_pkg::port_num_t  src_port,
   input  barrier_pkg::msg_t   message,
   input  barrier_pkg::topo_t  topo,
   input  barrier_pkg::node_t  node,
   input  logic                commit,
   output pkt_pkg::port_mask_t dst_mask,
   output logic                rewrite_msg,
   output barrier_pkg::msg_t   new_msg
);
   import pkt_pkg::*;
   import barrier_pkg::*;

   br_state_e state;
   br_state_e state_next;
   logic      from_cpu;       // odd ports face the cpu
   logic      ring;
   port_num_t peer_port;

   assign from_cpu  = src_port[0];
   assign ring      = is_barrier && (topo == TOPO_RING);
   assign peer_port = from_cpu ? src_port - 1'b1 : src_port + 1'b1;

   always_comb begin
      dst_mask    = '0;            // barrier packets nobody takes by default
      rewrite_msg = 1'b0;
      new_msg     = message;
      state_next  = state;
      if (!is_barrier) begin
         dst_mask = port_mask_t'(1) << peer_port;
      end else if (ring) begin
         if (node == NODE_HEAD && message == MSG_AT_BR && from_cpu && state == br_idle) begin
            dst_mask    = port_mask_t'(16'h0001);
            state_next  = at_barrier;
            rewrite_msg = 1'b1;
            new_msg     = MSG_PREV_AT_BR;
         end else if (message == MSG_PREV_AT_BR && !from_cpu && state == at_barrier) begin
            // token came all the way round, release everyone
            dst_mask    = port_mask_t'(16'h0003);
            state_next  = br_idle;
            rewrite_msg = 1'b1;
            new_msg     = MSG_RLS_BR;
         end else if (node == NODE_NODE && message == MSG_AT_BR && from_cpu &&
                      state == br_idle) begin
            state_next = wait_network;      // hold until upstream arrives
         end else if (message == MSG_PREV_AT_BR && !from_cpu && state == br_idle) begin
            state_next = wait_cpu;
         end else if (message == MSG_PREV_AT_BR && !from_cpu && state == wait_network) begin
            dst_mask   = port_mask_t'(16'h0001);
            state_next = wait_notification;
         end else if (message == MSG_AT_BR && from_cpu && state == wait_cpu) begin
            dst_mask    = port_mask_t'(16'h0001);
            state_next  = wait_notification;
            rewrite_msg = 1'b1;
            new_msg     = MSG_PREV_AT_BR;
         end else if (message == MSG_RLS_BR && !from_cpu && state == wait_notification) begin
            dst_mask   = port_mask_t'(16'h0003);   // pass on and tell the cpu
            state_next = br_idle;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= br_idle;
      else if (commit)
         state <= state_next;
   end

   a_state_legal: assert property (@(posedge clk) disable iff (reset)
      state inside {br_idle, at_barrier, wait_cpu, wait_network, wait_notification})
      else $error("barrier state left the legal set");

endmodule

// File: logic/output_ctrl.sv
// output streaming FSM with header mask and barrier message substitution
module output_ctrl (
   input  logic                clk,
   input  logic                reset,
   input  pkt_pkg::data_t      data_dout,
   input  pkt_pkg::ctrl_t      ctrl_dout,
   input  logic                data_empty,
   input  logic                desc_empty,
   input  pkt_pkg::port_mask_t dst_mask,
   input  logic                rewrite_msg,
   input  barrier_pkg::msg_t   new_msg,
   input  logic                out_rdy,
   output logic                data_rd,
   output logic                desc_rd,
   output logic                commit,
   output pkt_pkg::data_t      out_data,
   output pkt_pkg::ctrl_t      out_ctrl,
   output logic                out_wr
);
   import pkt_pkg::*;
   import barrier_pkg::*;

   typedef enum logic [1:0] {
      wait_desc,
      write_hdr,
      stream
   } oc_state_e;

   oc_state_e state;
   oc_state_e state_next;
   word_idx_t word_cnt;       // index of the word on data_dout
   word_idx_t word_cnt_next;
   logic      rewrite_q;      // decision held past the state update
   msg_t      msg_q;

   // -------------------------------------------------------------------------
   // next state and output word
   // -------------------------------------------------------------------------
   always_comb begin
      state_next    = state;
      word_cnt_next = word_cnt;
      data_rd       = 1'b0;
      desc_rd       = 1'b0;
      commit        = 1'b0;
      out_wr        = 1'b0;
      out_data      = data_dout;
      out_ctrl      = ctrl_dout;
      case (state)
         wait_desc: begin
            // descriptor only exists once the whole packet is buffered
            if (out_rdy && !desc_empty && !data_empty) begin
               desc_rd    = 1'b1;
               data_rd    = 1'b1;
               state_next = write_hdr;
            end
         end
         write_hdr: begin
            out_data[DST_MASK_LSB +: $bits(port_mask_t)] = dst_mask;
            if (out_rdy) begin
               out_wr        = 1'b1;
               commit        = 1'b1;
               data_rd       = 1'b1;
               word_cnt_next = word_idx_t'(1);
               state_next    = stream;
            end
         end
         stream: begin
            if (rewrite_q && word_cnt == word_idx_t'(BARRIER_WORD))
               out_data[MSG_LSB +: $bits(msg_t)] = msg_q;
            if (out_rdy) begin
               out_wr = 1'b1;
               if (ctrl_dout != '0) begin
                  state_next = wait_desc;     // last word out
               end else begin
                  data_rd = 1'b1;
                  if (word_cnt != '1)
                     word_cnt_next = word_cnt + 1'b1;
               end
            end
         end
         default: state_next = wait_desc;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= wait_desc;
         word_cnt  <= '0;
         rewrite_q <= 1'b0;
      end else begin
         state    <= state_next;
         word_cnt <= word_cnt_next;
         if (commit)
            rewrite_q <= rewrite_msg;
      end
   end

   always_ff @(posedge clk) begin
      if (commit)
         msg_q <= new_msg;
   end

   a_wr_needs_rdy: assert property (@(posedge clk) disable iff (reset) out_wr |-> out_rdy)
      else $error("out_wr raised without out_rdy");

endmodule

// File: logic/barrier_lookup.sv
// output port lookup top: parser, data and descriptor FIFOs, decision, output FSM
module barrier_lookup (
   input  logic           clk,
   input  logic           reset,
   input  pkt_pkg::data_t in_data,
   input  pkt_pkg::ctrl_t in_ctrl,
   input  logic           in_wr,
   output logic           in_rdy,
   output pkt_pkg::data_t out_data,
   output pkt_pkg::ctrl_t out_ctrl,
   output logic           out_wr,
   input  logic           out_rdy
);
   import pkt_pkg::*;
   import barrier_pkg::*;

   // parser side of the descriptor fifo
   logic       desc_wr;
   logic       is_barrier;
   port_num_t  src_port;
   msg_t       message;
   topo_t      topo;
   node_t      node;

   // current descriptor, held on the fifo output between pops
   logic       cur_barrier;
   port_num_t  cur_src;
   msg_t       cur_msg;
   topo_t      cur_topo;
   node_t      cur_node;

   data_t      data_dout;
   ctrl_t      ctrl_dout;
   logic       data_rd;
   logic       data_empty;
   logic       data_nearly_full;
   logic       desc_rd;
   logic       desc_empty;
   logic       desc_nearly_full;

   port_mask_t dst_mask;
   logic       rewrite_msg;
   msg_t       new_msg;
   logic       commit;

   // -------------------------------------------------------------------------
   // input side
   // -------------------------------------------------------------------------
   assign in_rdy = !data_nearly_full && !desc_nearly_full;

   barrier_parser parser (
      .clk        (clk),
      .reset      (reset),
      .in_data    (in_data),
      .in_ctrl    (in_ctrl),
      .in_wr      (in_wr),
      .desc_wr    (desc_wr),
      .is_barrier (is_barrier),
      .src_port   (src_port),
      .message    (message),
      .topo       (topo),
      .node       (node)
   );

   pkt_fifo #(.WIDTH(CTRL_W + DATA_W), .DEPTH_BITS(DATA_FIFO_DEPTH_BITS)) data_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_en       (in_wr),
      .din         ({in_ctrl, in_data}),
      .rd_en       (data_rd),
      .dout        ({ctrl_dout, data_dout}),
      .empty       (data_empty),
      .nearly_full (data_nearly_full),
      .full        ()
   );

   pkt_fifo #(.WIDTH(DESC_W), .DEPTH_BITS(DESC_FIFO_DEPTH_BITS)) desc_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_en       (desc_wr),
      .din         ({is_barrier, src_port, message, topo, node}),
      .rd_en       (desc_rd),
      .dout        ({cur_barrier, cur_src, cur_msg, cur_topo, cur_node}),
      .empty       (desc_empty),
      .nearly_full (desc_nearly_full),
      .full        ()
   );

   // -------------------------------------------------------------------------
   // decision and output side
   // -------------------------------------------------------------------------
   forward_decision decision (
      .clk         (clk),
      .reset       (reset),
      .is_barrier  (cur_barrier),
      .src_port    (cur_src),
      .message     (cur_msg),
      .topo        (cur_topo),
      .node        (cur_node),
      .commit      (commit),
      .dst_mask    (dst_mask),
      .rewrite_msg (rewrite_msg),
      .new_msg     (new_msg)
   );

   output_ctrl out_ctl (
      .clk         (clk),
      .reset       (reset),
      .data_dout   (data_dout),
      .ctrl_dout   (ctrl_dout),
      .data_empty  (data_empty),
      .desc_empty  (desc_empty),
      .dst_mask    (dst_mask),
      .rewrite_msg (rewrite_msg),
      .new_msg     (new_msg),
      .out_rdy     (out_rdy),
      .data_rd     (data_rd),
      .desc_rd     (desc_rd),
      .commit      (commit),
      .out_data    (out_data),
      .out_ctrl    (out_ctrl),
      .out_wr      (out_wr)
   );

endmodule

// File: tests/tb_barrier_lookup.sv
// testbench for barrier_lookup: case file loading, packet driver, output monitor, watchdog
module tb_barrier_lookup;
   timeunit 1ns;
   timeprecision 1ps;

   import pkt_pkg::*;
   import barrier_pkg::*;

   localparam int MAX_CASES = 64;
   localparam int FIELDS    = 8;        // columns per line of the case file

   logic  clk;
   logic  reset;
   data_t in_data;
   ctrl_t in_ctrl;
   logic  in_wr;
   logic  in_rdy;
   data_t out_data;
   ctrl_t out_ctrl;
   logic  out_wr;
   logic  out_rdy;

   logic [15:0] case_mem [FIELDS*MAX_CASES];
   logic [15:0] c_src [MAX_CASES];
   logic [15:0] c_len [MAX_CASES];
   logic [15:0] c_bar [MAX_CASES];
   logic [15:0] c_msg [MAX_CASES];
   logic [15:0] c_topo [MAX_CASES];
   logic [15:0] c_node [MAX_CASES];
   logic [15:0] c_mask [MAX_CASES];
   logic [15:0] c_exp_msg [MAX_CASES];

   logic [CTRL_W+DATA_W-1:0] exp_q [$];   // {ctrl, data} in output order
   int                       tag_q [$];   // case * 16 + word
   int          num_cases;
   int          total_words;
   int          received;
   int          data_errors;
   int          ctrl_errors;
   int          protocol_errors;
   logic        loaded;
   logic [31:0] in_rng;
   logic [31:0] out_rng;

   barrier_lookup uut (
      .clk      (clk),
      .reset    (reset),
      .in_data  (in_data),
      .in_ctrl  (in_ctrl),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .out_data (out_data),
      .out_ctrl (out_ctrl),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // ------------------------------------------------------------------------
   // packet words, payload is a pure function of case and word index
   // ------------------------------------------------------------------------
   function automatic data_t build_word(input int i, input int w);
      data_t d;
      d = {8'hc5, 8'(i), 8'(w), 8'h3c, 16'(i * 16 + w), ~16'(i * 16 + w)};
      if (w == 0) begin
         d[SRC_PORT_LSB +: 16] = c_src[i];
         d[DST_MASK_LSB +: 16] = 16'hbeef;    // stale mask, must be replaced
      end
      if (c_bar[i] != '0 && w == ETHERTYPE_WORD)
         d[ETHERTYPE_LSB +: 16] = BARRIER_ETHERTYPE;
      if (c_bar[i] != '0 && w == BARRIER_WORD) begin
         d[MSG_LSB +: 16] = c_msg[i];
         d[TOPO_LSB +: 8] = c_topo[i][7:0];
         d[NODE_LSB +: 8] = c_node[i][7:0];
      end
      return d;
   endfunction

   function automatic ctrl_t build_ctrl(input int i, input int w);
      if (w == 0)
         return IOQ_HDR_CTRL;
      else if (w == int'(c_len[i]) - 1)
         return ctrl_t'(8'h01 << w);         // one-hot end marker
      else
         return 8'h00;
   endfunction

   task automatic drive_word(input data_t d, input ctrl_t c);
      logic sent;
      sent = 1'b0;
      while (!sent) begin
         @(posedge clk);
         in_rng = xorshift(in_rng);
         if (in_rdy && in_rng[3:0] >= 4'd3) begin
            in_data <= d;
            in_ctrl <= c;
            in_wr   <= 1'b1;
            sent = 1'b1;
         end else begin
            in_wr <= 1'b0;                   // random gap or stalled
         end
      end
   endtask

   task automatic send_packet(input int i);
      data_t exp_data;
      // expected words are queued before the first word goes in
      for (int w = 0; w < int'(c_len[i]); w++) begin
         exp_data = build_word(i, w);
         if (w == 0)
            exp_data[DST_MASK_LSB +: 16] = c_mask[i];
         if (w == BARRIER_WORD && c_bar[i] != '0)
            exp_data[MSG_LSB +: 16] = c_exp_msg[i];
         exp_q.push_back({build_ctrl(i, w), exp_data});
         tag_q.push_back(i * 16 + w);
      end
      for (int w = 0; w < int'(c_len[i]); w++)
         drive_word(build_word(i, w), build_ctrl(i, w));
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      reset   <= 1'b1;
      in_data <= '0;
      in_ctrl <= '0;
      in_wr   <= 1'b0;
      out_rdy <= 1'b0;
      in_rng          = 32'd5;
      received        = 0;
      data_errors     = 0;
      ctrl_errors     = 0;
      protocol_errors = 0;
      loaded          = 1'b0;
      for (int k = 0; k < FIELDS * MAX_CASES; k++)
         case_mem[k] = '0;
      $readmemh("tests/lookup_cases.txt", case_mem);
      num_cases   = 0;
      total_words = 0;
      while (num_cases < MAX_CASES && case_mem[FIELDS * num_cases + 1] != '0) begin
         c_src[num_cases]     = case_mem[FIELDS * num_cases];
         c_len[num_cases]     = case_mem[FIELDS * num_cases + 1];
         c_bar[num_cases]     = case_mem[FIELDS * num_cases + 2];
         c_msg[num_cases]     = case_mem[FIELDS * num_cases + 3];
         c_topo[num_cases]    = case_mem[FIELDS * num_cases + 4];
         c_node[num_cases]    = case_mem[FIELDS * num_cases + 5];
         c_mask[num_cases]    = case_mem[FIELDS * num_cases + 6];
         c_exp_msg[num_cases] = case_mem[FIELDS * num_cases + 7];
         total_words = total_words + int'(c_len[num_cases]);
         num_cases++;
      end
      if (num_cases == 0) begin
         $display("No cases could be read from the case file");
         $display("Checks failed");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (16) @(posedge clk);
         reset <= 1'b0;
         @(posedge clk);
         if (!in_rdy || out_wr) begin
            $display("Error at %0t: in_rdy low or out_wr high right after reset", $time);
            protocol_errors++;
         end
         for (int i = 0; i < num_cases; i++)
            send_packet(i);
         @(posedge clk);
         in_wr <= 1'b0;
         while (received < total_words)
            @(posedge clk);
         repeat (8) @(posedge clk);       // catch stray words
         $display("%0d data errors, %0d control errors, %0d protocol errors, %0d words checked",
                  data_errors, ctrl_errors, protocol_errors, received);
         if (data_errors + ctrl_errors + protocol_errors == 0)
            $display("All checks passed");
         else
            $display("Checks failed");
         $finish;
      end
   end

   // random back-pressure
   initial begin
      out_rng = 32'd5;
      @(negedge reset);
      forever begin
         @(posedge clk);
         out_rng = xorshift(out_rng);
         out_rdy <= (out_rng[7:4] >= 4'd4);
      end
   end

   // ------------------------------------------------------------------------
   // output monitor
   // ------------------------------------------------------------------------
   initial begin : monitor
      logic [CTRL_W+DATA_W-1:0] exp_word;
      int                       tag;
      forever begin
         @(posedge clk);
         if (!reset && out_wr && !out_rdy) begin
            $display("Error at %0t: out_wr high while out_rdy is low", $time);
            protocol_errors++;
         end
         if (!reset && out_wr) begin
            if (exp_q.size() == 0) begin
               $display("Output word at %0t arrived with no packet pending", $time);
               protocol_errors++;
            end else begin
               exp_word = exp_q.pop_front();
               tag      = tag_q.pop_front();
               received++;
               if (out_ctrl !== exp_word[CTRL_W+DATA_W-1:DATA_W]) begin
                  $display("Error at %0t: case %0d word %0d ctrl %h, expected %h", $time,
                           tag / 16, tag % 16, out_ctrl, exp_word[CTRL_W+DATA_W-1:DATA_W]);
                  ctrl_errors++;
               end
               if (out_data !== exp_word[DATA_W-1:0]) begin
                  $display("Error at %0t: case %0d word %0d data %h, expected %h", $time,
                           tag / 16, tag % 16, out_data, exp_word[DATA_W-1:0]);
                  data_errors++;
               end
            end
         end
      end
   end

   // run limit scales with the amount of traffic
   initial begin : watchdog
      longint limit_ns;
      wait (loaded);
      limit_ns = longint'(total_words) * 20 * 8 + 16 * 20;
      #(limit_ns);
      $display("Run timed out after %0t with %0d of %0d words received",
               $time, received, total_words);
      $display("Checks failed");
      $finish;
   end

endmodule

// File: tests/lookup_cases.txt
// src_port len barrier msg topo node exp_mask exp_msg, all hex
// exp_msg is the word 3 message expected on barrier packets
3 5 0 0 0 0 0004 0
4 2 0 0 0 0 0020 0
0 3 0 0 0 0 0002 0
f 7 0 0 0 0 4000 0
1 4 1 41 1 1 0001 42
2 5 1 42 1 1 0003 43
2 4 1 43 1 2 0000 43
1 4 1 41 1 2 0000 41
2 6 1 42 2 2 0000 42
6 4 0 0 0 0 0080 0
2 4 1 42 1 2 0001 42
1 5 1 41 1 2 0000 41
2 4 1 43 1 2 0003 43
2 4 1 42 1 2 0000 42
1 7 1 41 1 2 0001 42
2 4 1 43 1 2 0003 43
2 4 1 43 1 2 0000 43
1 6 1 41 1 1 0001 42
3 4 1 42 1 1 0000 42
4 5 1 42 1 1 0003 43
9 2 0 0 0 0 0100 0

// File: tb.f
logic/pkt_pkg.sv
logic/barrier_pkg.sv
logic/pkt_fifo.sv
logic/barrier_parser.sv
logic/forward_decision.sv
logic/output_ctrl.sv
logic/barrier_lookup.sv
tests/tb_barrier_lookup.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_barrier_lookup
FILELIST = tb.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# fails when the simulator exits with an error or the log holds the fail message
run: compile
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
